//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen     = 64;   // one machine word
    localparam int alu_op_w = 5;

    typedef enum logic [alu_op_w-1:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_mul,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_divu,
        op_remu,
        op_div,
        op_rem
    } alu_op_e;

    // operations handled by the iterative divider
    function automatic logic is_div_op(alu_op_e op);
        return (op == op_divu) || (op == op_remu) || (op == op_div) || (op == op_rem);
    endfunction

    function automatic logic is_rem_op(alu_op_e op);
        return (op == op_remu) || (op == op_rem);
    endfunction

    function automatic logic is_signed_div(alu_op_e op);
        return (op == op_div) || (op == op_rem);
    endfunction

endpackage

`default_nettype wire

//--- hw/exu_cfg_pkg.sv
`default_nettype none

package exu_cfg_pkg;

    import rv_isa_pkg::*;

    localparam int issue_depth = 4;   // also the upstream credit count
    localparam int res_depth   = 4;
    localparam int out_credits = 2;
    localparam int tag_w       = 4;

    typedef struct packed {
        alu_op_e          op;
        logic             word;   // low 32 bits, sign-extended result
        logic [xlen-1:0]  src1;
        logic [xlen-1:0]  src2;
        logic [tag_w-1:0] tag;
    } op_entry_t;

    typedef struct packed {
        logic [xlen-1:0]  result;
        logic             cond;   // branch outcome
        logic [tag_w-1:0] tag;
    } res_entry_t;

endpackage

`default_nettype wire

//--- hw/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             push,
    input  wire payload_t                   push_data,
    input  wire                             pop,
    output payload_t                        pop_data,
    output logic                            empty,
    output logic                            full,
    output logic [$clog2(depth+1)-1:0]      count
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    payload_t mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;

    function automatic logic [aw-1:0] ptr_next(logic [aw-1:0] ptr);
        return (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == ($clog2(depth+1))'(depth));
    assign pop_data = mem[rd_ptr];   // head visible without read delay

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("credit_fifo: push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("credit_fifo: pop while empty");

endmodule

`default_nettype wire

//--- hw/exu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module exu_issue
    import rv_isa_pkg::*;
    import exu_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire alu_op_e          in_op,
    input  wire                   in_word,
    input  wire [xlen-1:0]        in_src1,
    input  wire [xlen-1:0]        in_src2,
    input  wire [tag_w-1:0]       in_tag,
    input  wire                   wb_ready,
    input  wire                   div_busy,
    output logic                  in_credit,
    output logic                  alu_start,
    output logic                  div_start,
    output alu_op_e               iss_op,
    output logic                  iss_word,
    output logic [xlen-1:0]       iss_src1,
    output logic [xlen-1:0]       iss_src2,
    output logic [tag_w-1:0]      iss_tag
);

    op_entry_t q_in;
    op_entry_t q_head;
    logic      q_empty;
    logic      dispatch;

    assign q_in = '{op: in_op, word: in_word, src1: in_src1, src2: in_src2, tag: in_tag};

    credit_fifo #(
        .payload_t (op_entry_t),
        .depth     (issue_depth)
    ) op_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (q_in),
        .pop       (dispatch),
        .pop_data  (q_head),
        .empty     (q_empty),
        .full      (),
        .count     ()
    );

    // div_start covers the cycle before div_busy rises
    assign dispatch = !q_empty && wb_ready && !div_busy && !div_start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_start <= 1'b0;
            div_start <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            alu_start <= dispatch && !is_div_op(q_head.op);
            div_start <= dispatch && is_div_op(q_head.op);
            in_credit <= dispatch;   // one credit per entry leaving
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            iss_op   <= q_head.op;
            iss_word <= q_head.word;
            iss_src1 <= q_head.src1;
            iss_src2 <= q_head.src2;
            iss_tag  <= q_head.tag;
        end
    end

    // no issue while a divide runs
    a_hold_busy: assert property (@(posedge clk) disable iff (!rst_n)
        div_busy |-> !(alu_start || div_start))
        else $error("exu_issue: operation started while the divider was busy");

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv_isa_pkg::*;
    import exu_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   alu_start,
    input  wire alu_op_e          iss_op,
    input  wire                   iss_word,
    input  wire [xlen-1:0]        iss_src1,
    input  wire [xlen-1:0]        iss_src2,
    input  wire [tag_w-1:0]       iss_tag,
    output logic                  alu_valid,
    output res_entry_t            alu_res
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [5:0]      shamt;
    logic [xlen-1:0] res_d;
    logic [xlen-1:0] res_w;
    logic            cond_d;

    always_comb begin
        // word mode works on the sign-extended low halves
        a      = iss_word ? {{32{iss_src1[31]}}, iss_src1[31:0]} : iss_src1;
        b      = iss_word ? {{32{iss_src2[31]}}, iss_src2[31:0]} : iss_src2;
        shamt  = iss_word ? {1'b0, iss_src2[4:0]} : iss_src2[5:0];
        res_d  = '0;
        cond_d = 1'b0;
        case (iss_op)
            op_add:  res_d = a + b;
            op_sub:  res_d = a - b;
            op_and:  res_d = a & b;
            op_or:   res_d = a | b;
            op_xor:  res_d = a ^ b;
            op_sll:  res_d = a << shamt;
            op_srl: begin
                if (iss_word) begin
                    res_d = {32'b0, a[31:0]} >> shamt;   // zero fill from bit 31
                end else begin
                    res_d = a >> shamt;
                end
            end
            op_sra:  res_d = $signed(a) >>> shamt;
            op_slt:  res_d = xlen'($signed(a) < $signed(b));
            op_sltu: res_d = xlen'(a < b);
            op_mul:  res_d = a * b;   // low half of product
            op_beq:  cond_d = (a == b);
            op_bne:  cond_d = (a != b);
            op_blt:  cond_d = ($signed(a) < $signed(b));
            op_bge:  cond_d = ($signed(a) >= $signed(b));
            op_bltu: cond_d = (a < b);
            op_bgeu: cond_d = (a >= b);
            default: res_d = '0;   // divider codes never arrive here
        endcase
        res_w = iss_word ? {{32{res_d[31]}}, res_d[31:0]} : res_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= alu_start;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_res <= '{result: res_w, cond: cond_d, tag: iss_tag};
        end
    end

endmodule

`default_nettype wire

//--- hw/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit
    import rv_isa_pkg::*;
    import exu_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   div_start,
    input  wire alu_op_e          iss_op,
    input  wire                   iss_word,
    input  wire [xlen-1:0]        iss_src1,
    input  wire [xlen-1:0]        iss_src2,
    input  wire [tag_w-1:0]       iss_tag,
    output logic                  div_busy,
    output logic                  div_done,
    output res_entry_t            div_res
);

    logic [6:0]       step_cnt;   // 0 prep, 1..64 steps, 65 finish
    logic [xlen-1:0]  a_q, b_q, quot_q, rem_q, dvs_q;
    logic             sgn_q, rem_op_q, word_q;
    logic [tag_w-1:0] tag_q;
    logic [xlen-1:0]  a_ext, b_ext, mag_a, mag_b, min_neg;
    logic [xlen-1:0]  q_fix, r_fix, res_fix;
    logic [xlen:0]    rem_sh, diff;
    logic             neg_a, neg_b, by_zero, ovf;

    always_comb begin
        a_ext = iss_src1;
        b_ext = iss_src2;
        if (iss_word) begin
            a_ext = {{32{is_signed_div(iss_op) & iss_src1[31]}}, iss_src1[31:0]};
            b_ext = {{32{is_signed_div(iss_op) & iss_src2[31]}}, iss_src2[31:0]};
        end
        neg_a   = sgn_q && a_q[xlen-1];
        neg_b   = sgn_q && b_q[xlen-1];
        mag_a   = neg_a ? -a_q : a_q;
        mag_b   = neg_b ? -b_q : b_q;
        rem_sh  = {rem_q, quot_q[xlen-1]};
        diff    = rem_sh - {1'b0, dvs_q};
        min_neg = word_q ? {{(xlen-31){1'b1}}, 31'b0} : {1'b1, {(xlen-1){1'b0}}};
        by_zero = (b_q == '0);
        ovf     = sgn_q && (a_q == min_neg) && (b_q == '1);
        q_fix   = (neg_a ^ neg_b) ? -quot_q : quot_q;
        r_fix   = neg_a ? -rem_q : rem_q;
        if (by_zero) begin
            q_fix = '1;
            r_fix = a_q;
        end else if (ovf) begin
            q_fix = a_q;
            r_fix = '0;
        end
        res_fix = rem_op_q ? r_fix : q_fix;
        if (word_q) begin
            res_fix = {{32{res_fix[31]}}, res_fix[31:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_busy <= 1'b0;
            div_done <= 1'b0;
            step_cnt <= '0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                div_busy <= 1'b1;
                step_cnt <= '0;
            end else if (div_busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == 7'd65) begin
                    div_busy <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            a_q      <= a_ext;
            b_q      <= b_ext;
            sgn_q    <= is_signed_div(iss_op);
            rem_op_q <= is_rem_op(iss_op);
            word_q   <= iss_word;
            tag_q    <= iss_tag;
        end else if (div_busy) begin
            if (step_cnt == 7'd0) begin
                quot_q <= mag_a;   // dividend shifts out as quotient shifts in
                dvs_q  <= mag_b;
                rem_q  <= '0;
            end else if (step_cnt <= 7'd64) begin
                rem_q  <= diff[xlen] ? rem_sh[xlen-1:0] : diff[xlen-1:0];
                quot_q <= {quot_q[xlen-2:0], !diff[xlen]};
            end else begin
                div_res <= '{result: res_fix, cond: 1'b0, tag: tag_q};
            end
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> !div_busy)
        else $error("div_unit: start while busy");
    a_start_op: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> is_div_op(iss_op))
        else $error("div_unit: non-divide operation dispatched");

endmodule

`default_nettype wire

//--- hw/exu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module exu_writeback
    import rv_isa_pkg::*;
    import exu_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   alu_valid,
    input  wire res_entry_t       alu_res,
    input  wire                   div_done,
    input  wire res_entry_t       div_res,
    input  wire                   out_credit,
    output logic                  wb_ready,
    output logic                  out_valid,
    output logic [xlen-1:0]       out_result,
    output logic                  out_cond,
    output logic [tag_w-1:0]      out_tag
);

    localparam int cw = $clog2(out_credits + 1);

    res_entry_t                       push_data;
    res_entry_t                       head;
    logic                             push;
    logic                             empty;
    logic [$clog2(res_depth+1)-1:0]   res_count;
    logic [cw-1:0]                    credits;

    assign push      = alu_valid || div_done;
    assign push_data = alu_valid ? alu_res : div_res;

    credit_fifo #(
        .payload_t (res_entry_t),
        .depth     (res_depth)
    ) res_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (out_valid),
        .pop_data  (head),
        .empty     (empty),
        .full      (),
        .count     (res_count)
    );

    // two slots free beyond the result being written now
    assign wb_ready = (res_depth - int'(res_count) - int'(push)) >= 2;

    assign out_valid  = !empty && (credits != '0);
    assign out_result = head.result;
    assign out_cond   = head.cond;
    assign out_tag    = head.tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= cw'(out_credits);
        end else if (out_valid && !out_credit) begin
            credits <= credits - 1'b1;
        end else if (out_credit && !out_valid) begin
            credits <= credits + 1'b1;
        end
    end

    a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_valid && div_done))
        else $error("exu_writeback: ALU and divider results collide");
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= cw'(out_credits))
        else $error("exu_writeback: more credits returned than issued");

endmodule

`default_nettype wire

//--- hw/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top
    import rv_isa_pkg::*;
    import exu_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire alu_op_e          in_op,
    input  wire                   in_word,
    input  wire [xlen-1:0]        in_src1,
    input  wire [xlen-1:0]        in_src2,
    input  wire [tag_w-1:0]       in_tag,
    output logic                  in_credit,
    output logic                  out_valid,
    output logic [xlen-1:0]       out_result,
    output logic                  out_cond,
    output logic [tag_w-1:0]      out_tag,
    input  wire                   out_credit
);

    logic             alu_start, div_start, div_busy, wb_ready;
    alu_op_e          iss_op;
    logic             iss_word;
    logic [xlen-1:0]  iss_src1, iss_src2;
    logic [tag_w-1:0] iss_tag;
    logic             alu_valid, div_done;
    res_entry_t       alu_res, div_res;

    exu_issue issue0 (
        .clk, .rst_n, .in_valid, .in_op, .in_word, .in_src1, .in_src2, .in_tag,
        .wb_ready, .div_busy, .in_credit, .alu_start, .div_start,
        .iss_op, .iss_word, .iss_src1, .iss_src2, .iss_tag
    );

    alu alu0 (
        .clk, .rst_n, .alu_start, .iss_op, .iss_word, .iss_src1, .iss_src2, .iss_tag,
        .alu_valid, .alu_res
    );

    div_unit div0 (
        .clk, .rst_n, .div_start, .iss_op, .iss_word, .iss_src1, .iss_src2, .iss_tag,
        .div_busy, .div_done, .div_res
    );

    exu_writeback wb0 (
        .clk, .rst_n, .alu_valid, .alu_res, .div_done, .div_res, .out_credit,
        .wb_ready, .out_valid, .out_result, .out_cond, .out_tag
    );

endmodule

`default_nettype wire

//--- bench/tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu
    import rv_isa_pkg::*;
    import exu_cfg_pkg::*;
();

    localparam int n_alu_rand      = 40;
    localparam int n_branch        = 24;
    localparam int n_div           = 38;
    localparam int n_bp            = 16;
    localparam int n_ops           = n_alu_rand + n_branch + n_div + n_bp;
    localparam int reset_cycles    = 16;
    localparam int watchdog_cycles = n_ops * 100 + reset_cycles;

    typedef struct packed {
        logic [xlen-1:0]  result;
        logic             cond;
        logic [tag_w-1:0] tag;
        alu_op_e          op;
    } exp_t;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_valid;
    alu_op_e          in_op;
    logic             in_word;
    logic [xlen-1:0]  in_src1;
    logic [xlen-1:0]  in_src2;
    logic [tag_w-1:0] in_tag;
    logic             in_credit;
    logic             out_valid;
    logic [xlen-1:0]  out_result;
    logic             out_cond;
    logic [tag_w-1:0] out_tag;
    logic             out_credit = 1'b0;

    exp_t             exp_q [$];
    logic [31:0]      lfsr_state;
    logic [tag_w-1:0] next_tag;
    logic             consumer_stall = 1'b0;
    int               sent_cnt = 0;
    int               accepted_cnt = 0;
    int               credit_cnt = 0;   // in_credit pulses seen
    int               result_cnt = 0;
    int               credit_back_cnt = 0;
    int               ret_delay = 0;
    int               mismatch_cnt = 0;
    int               monitor_err_cnt = 0;
    int               test_err_cnt = 0;

    exu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_tag     (in_tag),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_cond   (out_cond),
        .out_tag    (out_tag),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [xlen-1:0] rand_word();
        logic [xlen-1:0] v;
        v = '0;
        for (int i = 0; i < xlen; i++) begin
            v = {v[xlen-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int unsigned rand_small(int nbits);
        int unsigned v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            v = (v << 1) | {31'b0, lfsr_bit()};
        end
        return v;
    endfunction

    // RISC-V divide and remainder on full-width operands
    function automatic logic [xlen-1:0] div_ref(alu_op_e op, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic [xlen-1:0]        q;
        logic [xlen-1:0]        r;
        logic                   sgn;
        sa  = a;
        sb  = b;
        sgn = (op == op_div) || (op == op_rem);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == {1'b1, {(xlen-1){1'b0}}} && b == '1) begin
            q = a;   // signed overflow
            r = '0;
        end else if (sgn) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == op_remu || op == op_rem) ? r : q;
    endfunction

    // returns {cond, result}
    function automatic logic [xlen:0] expected_out(alu_op_e op, logic word,
                                                   logic [xlen-1:0] a, logic [xlen-1:0] b);
        logic [31:0]     aw;
        logic [31:0]     bw;
        logic [31:0]     rw;
        logic [xlen-1:0] r;
        logic            c;
        logic            sgn;
        aw  = a[31:0];
        bw  = b[31:0];
        rw  = '0;
        r   = '0;
        c   = 1'b0;
        sgn = (op == op_div) || (op == op_rem);
        if (op == op_divu || op == op_remu || op == op_div || op == op_rem) begin
            if (word) begin
                r = div_ref(op, {{32{sgn & a[31]}}, aw}, {{32{sgn & b[31]}}, bw});
                r = {{32{r[31]}}, r[31:0]};
            end else begin
                r = div_ref(op, a, b);
            end
        end else if (word) begin
            case (op)
                op_add:  rw = aw + bw;
                op_sub:  rw = aw - bw;
                op_and:  rw = aw & bw;
                op_or:   rw = aw | bw;
                op_xor:  rw = aw ^ bw;
                op_sll:  rw = aw << bw[4:0];
                op_srl:  rw = aw >> bw[4:0];
                op_sra:  rw = $signed(aw) >>> bw[4:0];
                op_slt:  rw = {31'b0, $signed(aw) < $signed(bw)};
                op_sltu: rw = {31'b0, aw < bw};
                op_mul:  rw = aw * bw;
                op_beq:  c = (aw == bw);
                op_bne:  c = (aw != bw);
                op_blt:  c = ($signed(aw) < $signed(bw));
                op_bge:  c = ($signed(aw) >= $signed(bw));
                op_bltu: c = (aw < bw);
                op_bgeu: c = (aw >= bw);
                default: rw = '0;
            endcase
            r = {{32{rw[31]}}, rw};
        end else begin
            case (op)
                op_add:  r = a + b;
                op_sub:  r = a - b;
                op_and:  r = a & b;
                op_or:   r = a | b;
                op_xor:  r = a ^ b;
                op_sll:  r = a << b[5:0];
                op_srl:  r = a >> b[5:0];
                op_sra:  r = $signed(a) >>> b[5:0];
                op_slt:  r = {63'b0, $signed(a) < $signed(b)};
                op_sltu: r = {63'b0, a < b};
                op_mul:  r = a * b;
                op_beq:  c = (a == b);
                op_bne:  c = (a != b);
                op_blt:  c = ($signed(a) < $signed(b));
                op_bge:  c = ($signed(a) >= $signed(b));
                op_bltu: c = (a < b);
                op_bgeu: c = (a >= b);
                default: r = '0;
            endcase
        end
        return {c, r};
    endfunction

    task automatic send_op(alu_op_e op, logic word, logic [xlen-1:0] a, logic [xlen-1:0] b);
        exp_t e;
        @(posedge clk);
        in_valid <= 1'b0;
        while (sent_cnt - credit_cnt >= issue_depth) begin   // out of source credits
            @(posedge clk);
        end
        {e.cond, e.result} = expected_out(op, word, a, b);
        e.tag = next_tag;
        e.op  = op;
        exp_q.push_back(e);
        in_valid <= 1'b1;
        in_op    <= op;
        in_word  <= word;
        in_src1  <= a;
        in_src2  <= b;
        in_tag   <= next_tag;
        next_tag = next_tag + 1'b1;
        sent_cnt++;
    endtask

    task automatic end_burst();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        end_burst();
        while (exp_q.size() != 0 || credit_back_cnt != result_cnt) begin
            @(posedge clk);
        end
    endtask

    task automatic check_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
                $display("error at %0t: output active after reset with nothing sent", $time);
                test_err_cnt++;
            end
        end
    endtask

    task automatic run_alu_random();
        alu_op_e         op;
        logic            w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        for (int i = 0; i < n_alu_rand; i++) begin
            op = alu_op_e'(5'(rand_small(4) % 11));   // op_add up to op_mul
            w  = lfsr_bit();
            a  = rand_word();
            b  = rand_word();
            send_op(op, w, a, b);
        end
        wait_drain();
    endtask

    task automatic run_branches();
        logic [xlen-1:0] p;
        logic [xlen-1:0] n;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        for (int k = 0; k < 4; k++) begin
            p = rand_word() & {2'b00, {(xlen-2){1'b1}}};
            n = rand_word() | {1'b1, {(xlen-1){1'b0}}};
            case (k)
                0:       {a, b} = {p, p};          // equal
                1:       {a, b} = {p, p + 1'b1};   // less
                2:       {a, b} = {n, p};          // signed less and unsigned greater
                default: {a, b} = {p + 1'b1, p};   // greater
            endcase
            for (int j = 0; j < 6; j++) begin
                send_op(alu_op_e'(5'(int'(op_beq) + j)), 1'b0, a, b);
            end
        end
        wait_drain();
    endtask

    task automatic run_divides();
        alu_op_e         op;
        logic            w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        for (int i = 0; i < 10; i++) begin
            op = alu_op_e'(5'(int'(op_divu) + rand_small(2)));
            w  = lfsr_bit();
            a  = rand_word();
            b  = rand_word() >> rand_small(6);   // spread divisor sizes
            send_op(op, w, a, b);
        end
        for (int j = 0; j < 4; j++) begin
            send_op(alu_op_e'(5'(int'(op_divu) + j)), 1'b0, rand_word(), '0);
        end
        send_op(op_divu, 1'b1, rand_word() | 64'hffff_ffff_0000_0000, 64'hffff_ffff_0000_0000);
        send_op(op_remu, 1'b1, rand_word(), 64'hffff_ffff_0000_0000);
        send_op(op_div, 1'b0, 64'h8000_0000_0000_0000, '1);
        send_op(op_rem, 1'b0, 64'h8000_0000_0000_0000, '1);
        send_op(op_div, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
        send_op(op_rem, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
        // divides mixed with ALU work behind them
        for (int i = 0; i < 6; i++) begin
            op = alu_op_e'(5'(int'(op_divu) + rand_small(2)));
            a  = rand_word();
            b  = rand_word() >> rand_small(6);
            send_op(op, 1'b0, a, b);
            for (int m = 0; m < 2; m++) begin
                op = alu_op_e'(5'(rand_small(4) % 11));
                a  = rand_word();
                b  = rand_word();
                send_op(op, 1'b1, a, b);
            end
        end
        wait_drain();
    endtask

    task automatic run_backpressure();
        int              res_start;
        int              cred_mid;
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        while (credit_back_cnt != result_cnt) begin
            @(posedge clk);
        end
        consumer_stall <= 1'b1;
        res_start = result_cnt;
        fork
            begin
                for (int i = 0; i < n_bp; i++) begin
                    op = alu_op_e'(5'(rand_small(4) % 11));
                    a  = rand_word();
                    b  = rand_word();
                    send_op(op, 1'b0, a, b);
                end
                end_burst();
            end
            begin
                repeat (40) @(posedge clk);
                cred_mid = credit_cnt;
                repeat (20) @(posedge clk);
                if (result_cnt - res_start > out_credits) begin
                    $display("error at %0t: %0d results left while the consumer was stalled",
                             $time, result_cnt - res_start);
                    test_err_cnt++;
                end
                if (credit_cnt != cred_mid) begin
                    $display("error at %0t: issue credits still returned with queues full", $time);
                    test_err_cnt++;
                end
                consumer_stall <= 1'b0;
            end
        join
        wait_drain();
    endtask

    task automatic check_credit_totals();
        repeat (4) @(posedge clk);
        if (credit_cnt != sent_cnt || accepted_cnt != sent_cnt) begin
            $display("error: %0d operations sent, %0d accepted, %0d issue credits returned",
                     sent_cnt, accepted_cnt, credit_cnt);
            test_err_cnt++;
        end
        if (sent_cnt != n_ops) begin
            $display("error: %0d operations sent instead of %0d", sent_cnt, n_ops);
            test_err_cnt++;
        end
    endtask

    always @(negedge clk) begin : monitor
        exp_t e;
        if (rst_n) begin
            if (in_credit) begin
                if (credit_cnt >= accepted_cnt) begin
                    $display("error at %0t: issue credit returned with no operation outstanding",
                             $time);
                    monitor_err_cnt++;
                end
                credit_cnt++;
            end
            if (in_valid) begin
                accepted_cnt++;
            end
            if (out_valid) begin
                result_cnt++;
                if (exp_q.size() == 0) begin
                    $display("error at %0t: result tag %0d with nothing outstanding",
                             $time, out_tag);
                    monitor_err_cnt++;
                end else begin
                    e = exp_q.pop_front();
                    if (out_tag != e.tag) begin
                        $display("mismatch at %0t: tag %0d, expected tag %0d", $time,
                                 out_tag, e.tag);
                        mismatch_cnt++;
                    end
                    if (out_result != e.result) begin
                        $display("mismatch at %0t: tag %0d %s result %h, expected %h", $time,
                                 e.tag, e.op.name(), out_result, e.result);
                        mismatch_cnt++;
                    end
                    if (out_cond != e.cond) begin
                        $display("mismatch at %0t: tag %0d %s cond %b, expected %b", $time,
                                 e.tag, e.op.name(), out_cond, e.cond);
                        mismatch_cnt++;
                    end
                end
            end
        end
    end

    // consumer returns one credit every few cycles unless stalled
    always @(posedge clk) begin
        if (!rst_n) begin
            out_credit <= 1'b0;
        end else begin
            out_credit <= 1'b0;
            if (!consumer_stall && result_cnt > credit_back_cnt) begin
                if (ret_delay == 0) begin
                    out_credit      <= 1'b1;
                    credit_back_cnt <= credit_back_cnt + 1;
                    ret_delay = 2;
                end else begin
                    ret_delay--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = op_add;
        in_word    = 1'b0;
        in_src1    = '0;
        in_src2    = '0;
        in_tag     = '0;
        next_tag   = '0;
        lfsr_state = 32'h8020_2c82;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        check_idle_after_reset();
        run_alu_random();
        run_branches();
        run_divides();
        run_backpressure();
        check_credit_totals();
        total = mismatch_cnt + monitor_err_cnt + test_err_cnt;
        $display("mismatches %0d, monitor errors %0d, test errors %0d",
                 mismatch_cnt, monitor_err_cnt, test_err_cnt);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/rv_isa_pkg.sv
hw/exu_cfg_pkg.sv
hw/credit_fifo.sv
hw/exu_issue.sv
hw/alu.sv
hw/div_unit.sv
hw/exu_writeback.sv
hw/exu_top.sv
bench/tb_exu.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_exu -f flist.f -o Vtb_exu

status=0
./obj_dir/Vtb_exu > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed with status ${status}, see sim.log"
    exit 1
fi
